// File: verification/led_ctrl_trace.txt
# name mode row_mask col_mask extra_bytes(decimal) exp_row_union exp_cells, all else hex
# exp_cells is the cell word on any lit row, three bits per column, column 0 lowest
on_red          05 81 0f  0 81 000249
on_white_extra  1d ff ff  6 ff ffffff
replace_green   09 3c f0  0 3c 492000
off_mode        1c ff ff  0 00 000000
unknown_mode2   1e ff ff  3 00 000000
unknown_mode3   0f 7e 7e  0 00 000000
overflow_frame  11 55 aa 20 55 820820
fill_exact      0d 02 01 13 02 000003
zero_rows       19 00 ff  0 00 db6db6
zero_cols       15 f0 00  0 f0 000000
back_on         19 18 3c  2 18 036d80

// File: tb.f
+incdir+rtl
rtl/spi_link_pkg.sv
rtl/matrix_pkg.sv
rtl/spi_byte_rx.sv
rtl/cmd_buffer.sv
rtl/instr_fetch.sv
rtl/matrix_scan.sv
rtl/led_ctrl_top.sv
verification/led_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= led_ctrl_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/led_ctrl_tb.sv
// Run from the project root so the trace path resolves; peeks at the top-level cmd_ack handshake
`include "led_ctrl_config.svh"

module led_ctrl_tb import matrix_pkg::*; ();
    localparam int SCAN_CYCLES = `LED_ROW_NUM * `LED_ROW_DWELL;
    localparam int HALF_BIT    = 4;
    localparam int WAIT_LIMIT  = 200;

    logic        sys_clk;
    logic        rst_n;
    logic        spi_clk;
    logic        spi_ss_n;
    logic        spi_mosi;
    logic        tx_done;
    row_mask_t   row_anode;
    col_cells_t  col_cells;

    logic [31:0] rng_state;
    int          trace_fd;
    int          status;
    int          tests_run;
    string       trace_line;
    string       test_name;
    logic [7:0]  t_mode;
    logic [7:0]  t_rows;
    logic [7:0]  t_cols;
    int          t_extra;
    logic [7:0]  exp_rows;
    logic [23:0] exp_cells;

    led_ctrl_top led_ctrl_top_i (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .spi_clk   (spi_clk),
        .spi_ss_n  (spi_ss_n),
        .spi_mosi  (spi_mosi),
        .tx_done   (tx_done),
        .row_anode (row_anode),
        .col_cells (col_cells)
    );

    always #4 sys_clk = ~sys_clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string reason);
        $display("ERROR %s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sys_clk);
    endtask

    task automatic wait_ack(input logic level, input string name);
        int waited;
        waited = 0;
        while (led_ctrl_top_i.cmd_ack !== level) begin
            if (waited == WAIT_LIMIT) begin
                abort_run($sformatf("%s: handshake ack did not go to %0b within %0d cycles",
                                    name, level, WAIT_LIMIT));
            end
            @(posedge sys_clk);
            waited++;
        end
    endtask

    // Mode 0, data changes while spi_clk is low
    task automatic shift_out_byte(input logic [7:0] data);
        for (int b = 7; b >= 0; b--) begin
            spi_mosi <= data[b];
            wait_cycles(HALF_BIT);
            spi_clk <= 1'b1;
            wait_cycles(HALF_BIT);
            spi_clk <= 1'b0;
        end
    endtask

    task automatic send_frame(input logic [7:0] mode, input logic [7:0] rows,
                              input logic [7:0] cols, input int extra);
        logic [7:0] filler;
        @(posedge sys_clk);
        spi_ss_n <= 1'b0;
        wait_cycles(HALF_BIT);
        shift_out_byte(mode);
        shift_out_byte(rows);
        shift_out_byte(cols);
        for (int i = 0; i < extra; i++) begin
            rng_state = xorshift(rng_state);
            filler = rng_state[7:0];
            shift_out_byte(filler);
        end
        // Let the last byte reach the buffer before deselect
        wait_cycles(2 * HALF_BIT);
        spi_ss_n <= 1'b1;
    endtask

    // Two full scans, sampled away from the active edge
    task automatic observe_scan(input string name, input logic [7:0] rows_exp,
                                input logic [23:0] cells_exp);
        row_mask_t rows_seen;
        rows_seen = '0;
        repeat (2 * SCAN_CYCLES) begin
            @(negedge sys_clk);
            rows_seen = rows_seen | row_anode;
            check_value({name, " one_hot"}, 32'(1), 32'($onehot0(row_anode)));
            if (row_anode != '0) begin
                check_value({name, " cells"}, 32'(cells_exp), 32'(col_cells));
            end else begin
                check_value({name, " blank"}, 32'(0), 32'(col_cells));
            end
        end
        check_value({name, " rows"}, 32'(rows_exp), 32'(rows_seen));
    endtask

    task automatic run_command(input string name);
        rng_state = xorshift(rng_state);
        wait_cycles(1 + int'(rng_state[2:0]));
        send_frame(t_mode, t_rows, t_cols, t_extra);
        rng_state = xorshift(rng_state);
        wait_cycles(2 + int'(rng_state[3:0]));
        tx_done <= 1'b1;
        wait_ack(1'b1, name);
        tx_done <= 1'b0;
        wait_ack(1'b0, name);
        // New instruction lands at the next row slot
        wait_cycles(SCAN_CYCLES);
        observe_scan(name, exp_rows, exp_cells);
    endtask

    initial begin
        sys_clk   = 1'b0;
        rst_n     = 1'b0;
        spi_clk   = 1'b0;
        spi_ss_n  = 1'b1;
        spi_mosi  = 1'b0;
        tx_done   = 1'b0;
        rng_state = 32'h74aa;
        tests_run = 0;
        wait_cycles(4);
        rst_n <= 1'b1;

        // No command yet, matrix stays dark
        observe_scan("reset_idle", 8'h00, 24'h000000);

        trace_fd = $fopen("verification/led_ctrl_trace.txt", "r");
        if (trace_fd == 0) begin
            abort_run("could not open verification/led_ctrl_trace.txt");
        end
        while (!$feof(trace_fd)) begin
            trace_line = "";
            status = $fgets(trace_line, trace_fd);
            if (trace_line.len() < 2 || trace_line[0] == "#") begin
                continue;
            end
            status = $sscanf(trace_line, "%s %h %h %h %d %h %h", test_name, t_mode,
                             t_rows, t_cols, t_extra, exp_rows, exp_cells);
            if (status != 7) begin
                abort_run({"trace line could not be parsed: ", trace_line});
            end
            run_command(test_name);
            tests_run++;
        end
        $fclose(trace_fd);

        if (tests_run == 0) begin
            abort_run("trace file held no commands");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: rtl/led_ctrl_top.sv
// SPI commanded LED matrix; tx_done must be held until the frame's last byte is stored
module led_ctrl_top import spi_link_pkg::*, matrix_pkg::*; (
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic       spi_clk,
    input  logic       spi_ss_n,
    input  logic       spi_mosi,
    input  logic       tx_done,
    output row_mask_t  row_anode,
    output col_cells_t col_cells
);
    logic          rx_valid;
    rx_byte_t      rx_byte;
    buf_addr_t     rd_addr;
    spi_byte_t     rd_data;
    logic          cmd_req;
    logic          cmd_ack;
    matrix_instr_t cmd;

    spi_byte_rx spi_byte_rx_i (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .spi_clk  (spi_clk),
        .spi_ss_n (spi_ss_n),
        .spi_mosi (spi_mosi),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    cmd_buffer cmd_buffer_i (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    // Decode stage
    instr_fetch instr_fetch_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .tx_done (tx_done),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .cmd_ack (cmd_ack)
    );

    // Execute stage
    matrix_scan matrix_scan_i (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .cmd_req   (cmd_req),
        .cmd       (cmd),
        .cmd_ack   (cmd_ack),
        .row_anode (row_anode),
        .col_cells (col_cells)
    );

endmodule

// File: rtl/matrix_scan.sv
// Fixed dwell row scan, no brightness control; a new instruction applies from the next row slot
`include "led_ctrl_config.svh"

module matrix_scan import matrix_pkg::*; (
    input  logic          sys_clk,
    input  logic          rst_n,
    input  logic          cmd_req,
    input  matrix_instr_t cmd,
    output logic          cmd_ack,
    output row_mask_t     row_anode,
    output col_cells_t    col_cells
);
    localparam int unsigned ROW_W   = $clog2(`LED_ROW_NUM);
    localparam int unsigned DWELL_W = $clog2(`LED_ROW_DWELL + 1);
    localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(`LED_ROW_DWELL - 1);
    localparam logic [ROW_W-1:0]   ROW_LAST   = ROW_W'(`LED_ROW_NUM - 1);

    matrix_instr_t      instr_pend;
    matrix_instr_t      instr_cur;
    logic [DWELL_W-1:0] dwell_cnt;
    logic [ROW_W-1:0]   row_idx;
    logic               row_on;

    // Four-phase slave side
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            cmd_ack    <= 1'b0;
            instr_pend <= '0;
        end else if (cmd_req && !cmd_ack) begin
            instr_pend <= cmd;
            cmd_ack    <= 1'b1;
        end else if (!cmd_req && cmd_ack) begin
            cmd_ack <= 1'b0;
        end
    end

    // Row slot timing, instruction swapped only at slot edges
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            dwell_cnt <= '0;
            row_idx   <= '0;
            instr_cur <= '0;
        end else if (dwell_cnt == DWELL_LAST) begin
            dwell_cnt <= '0;
            instr_cur <= instr_pend;
            if (row_idx == ROW_LAST) begin
                row_idx <= '0;
            end else begin
                row_idx <= row_idx + 1'b1;
            end
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    assign row_on = (instr_cur.mode.sel == MODE_ON) && instr_cur.row[row_idx];

    always_comb begin
        row_anode = row_on ? (row_mask_t'(1) << row_idx) : '0;
        for (int c = 0; c < `LED_COL_NUM; c++) begin
            col_cells[c] = (row_on && instr_cur.col[c]) ? instr_cur.mode.color : '0;
        end
    end

endmodule

// File: rtl/instr_fetch.sv
// Fetches bytes 0..2 once per tx_done pulse; tx_done must fall before the next fetch starts
module instr_fetch import spi_link_pkg::*, matrix_pkg::*; (
    input  logic          sys_clk,
    input  logic          rst_n,
    input  logic          tx_done,
    output buf_addr_t     rd_addr,
    input  spi_byte_t     rd_data,
    output logic          cmd_req,
    output matrix_instr_t cmd,
    input  logic          cmd_ack
);
    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_MODE,
        S_RD_ROW,
        S_RD_COL,
        S_LOAD,
        S_REQ,
        S_HOLD,
        S_REARM
    } fetch_state_t;

    fetch_state_t state;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            rd_addr <= '0;
            cmd_req <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (tx_done) begin
                        rd_addr <= buf_addr_t'(0);
                        state   <= S_RD_MODE;
                    end
                end
                // Buffer samples the address here and returns data next cycle
                S_RD_MODE: begin
                    rd_addr <= buf_addr_t'(1);
                    state   <= S_RD_ROW;
                end
                S_RD_ROW: begin
                    rd_addr <= buf_addr_t'(2);
                    state   <= S_RD_COL;
                end
                S_RD_COL: state <= S_LOAD;
                S_LOAD:   state <= S_REQ;
                // Instruction complete in cmd
                S_REQ: begin
                    cmd_req <= 1'b1;
                    state   <= S_HOLD;
                end
                S_HOLD: begin
                    if (cmd_ack) begin
                        cmd_req <= 1'b0;
                        state   <= S_REARM;
                    end
                end
                S_REARM: begin
                    if (!cmd_ack && !tx_done) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Instruction fields only change while req is low
    always_ff @(posedge sys_clk) begin
        case (state)
            S_RD_ROW: cmd.mode <= rd_data;
            S_RD_COL: cmd.row  <= rd_data;
            S_LOAD:   cmd.col  <= rd_data;
            default:  cmd      <= cmd;
        endcase
    end

endmodule

// File: rtl/cmd_buffer.sv
// Register byte store; bytes past LED_BUF_DEPTH in one frame are dropped, reads take one cycle
`include "led_ctrl_config.svh"

module cmd_buffer import spi_link_pkg::*; (
    input  logic      sys_clk,
    input  logic      rst_n,
    input  logic      rx_valid,
    input  rx_byte_t  rx_byte,
    input  buf_addr_t rd_addr,
    output spi_byte_t rd_data
);
    localparam buf_addr_t LAST_ADDR = buf_addr_t'(`LED_BUF_DEPTH - 1);

    spi_byte_t mem [`LED_BUF_DEPTH];
    buf_addr_t wr_ptr;
    buf_addr_t wr_idx;
    logic      wr_full;
    logic      wr_en;

    // A frame's first byte always lands at address 0
    assign wr_idx = rx_byte.frame_first ? '0 : wr_ptr;
    assign wr_en  = rx_valid & (rx_byte.frame_first | ~wr_full);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            wr_full <= 1'b0;
        end else if (wr_en) begin
            if (wr_idx == LAST_ADDR) begin
                wr_full <= 1'b1;
            end else begin
                wr_ptr  <= wr_idx + 1'b1;
                wr_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            mem[wr_idx] <= rx_byte.data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// File: rtl/spi_byte_rx.sv
// SPI mode 0 slave, MSB first; spi_clk must stay at or below sys_clk/8, no MISO path
`include "led_ctrl_config.svh"

module spi_byte_rx import spi_link_pkg::*; (
    input  logic     sys_clk,
    input  logic     rst_n,
    input  logic     spi_clk,
    input  logic     spi_ss_n,
    input  logic     spi_mosi,
    output logic     rx_valid,
    output rx_byte_t rx_byte
);
    localparam int unsigned CNT_W = $clog2(`LED_DATA_WIDTH);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`LED_DATA_WIDTH - 1);

    logic [1:0]       sclk_sync;
    logic [1:0]       ss_sync;
    logic [1:0]       mosi_sync;
    logic             sclk_prev;
    logic             ss_prev;
    logic             sclk_rise;
    logic             ss_fall;
    logic             shift_en;
    logic [CNT_W-1:0] bit_cnt;
    logic             first_pend;
    spi_byte_t        shift_reg;
    spi_byte_t        shift_next;

    assign sclk_rise  = sclk_sync[1] & ~sclk_prev;
    assign ss_fall    = ~ss_sync[1] & ss_prev;
    assign shift_en   = sclk_rise & ~ss_sync[1] & ~ss_fall;
    assign shift_next = {shift_reg[`LED_DATA_WIDTH-2:0], mosi_sync[1]};

    // Synchronizers and bit counter
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            sclk_sync  <= '0;
            ss_sync    <= '1;
            sclk_prev  <= 1'b0;
            ss_prev    <= 1'b1;
            bit_cnt    <= '0;
            first_pend <= 1'b0;
            rx_valid   <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_clk};
            ss_sync   <= {ss_sync[0], spi_ss_n};
            sclk_prev <= sclk_sync[1];
            ss_prev   <= ss_sync[1];
            rx_valid  <= 1'b0;
            if (ss_fall) begin
                bit_cnt    <= '0;
                first_pend <= 1'b1;
            end else if (ss_sync[1]) begin
                // Deselect drops any partial byte
                bit_cnt <= '0;
            end else if (shift_en) begin
                if (bit_cnt == LAST_BIT) begin
                    bit_cnt    <= '0;
                    rx_valid   <= 1'b1;
                    first_pend <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // Data path, mosi delayed to line up with spi_clk
    always_ff @(posedge sys_clk) begin
        mosi_sync <= {mosi_sync[0], spi_mosi};
        if (shift_en) begin
            shift_reg <= shift_next;
        end
        if (shift_en && bit_cnt == LAST_BIT) begin
            rx_byte.data        <= shift_next;
            rx_byte.frame_first <= first_pend;
        end
    end

endmodule

// File: rtl/matrix_pkg.sv
// Matrix instruction types; the mode byte layout assumes three control pins per cell
`include "led_ctrl_config.svh"

package matrix_pkg;

    // Display mode, only MODE_ON lights anything
    typedef enum logic [1:0] {
        MODE_OFF = 2'd0,
        MODE_ON  = 2'd1
    } disp_mode_t;

    typedef logic [`LED_CONTROL_NUM-1:0] color_t;
    typedef logic [`LED_ROW_NUM-1:0]     row_mask_t;
    typedef logic [`LED_COL_NUM-1:0]     col_mask_t;

    // Mode byte: bits 1..0 mode, bits 4..2 colour, top bits unused
    typedef struct packed {
        logic [2:0] rsvd;
        color_t     color;
        disp_mode_t sel;
    } mode_byte_t;

    typedef struct packed {
        mode_byte_t mode;
        row_mask_t  row;
        col_mask_t  col;
    } matrix_instr_t;

    // One colour code per column
    typedef color_t [`LED_COL_NUM-1:0] col_cells_t;

endpackage

// File: rtl/spi_link_pkg.sv
// SPI byte path types; buffer address width follows LED_BUF_DEPTH, which must be a power of two
`include "led_ctrl_config.svh"

package spi_link_pkg;

    // One byte as shifted in from mosi
    typedef logic [`LED_DATA_WIDTH-1:0] spi_byte_t;

    // Command buffer address
    typedef logic [$clog2(`LED_BUF_DEPTH)-1:0] buf_addr_t;

    // Received byte with the first-in-frame mark
    typedef struct packed {
        spi_byte_t data;
        logic      frame_first;
    } rx_byte_t;

endpackage

// File: rtl/led_ctrl_config.svh
// Sizes are fixed at compile time; LED_DATA_WIDTH must match the row and column mask widths
`ifndef LED_CTRL_CONFIG_SVH
`define LED_CTRL_CONFIG_SVH

// SPI byte size in bits
`define LED_DATA_WIDTH 8

// Command buffer depth in bytes, extra frame bytes are dropped
`define LED_BUF_DEPTH 16

// Matrix geometry
`define LED_ROW_NUM 8
`define LED_COL_NUM 8

// Red, green and blue pins per cell
`define LED_CONTROL_NUM 3

// sys_clk cycles spent on each scanned row
`define LED_ROW_DWELL 4

`endif
